//--- isa_pkg.sv
package isa_pkg;

    typedef logic [15:0] word_t;                // Data or instruction word
    typedef logic [15:0] addr_t;                // Instruction address
    typedef logic [2:0]  reg_idx_t;             // Register number, r0 to r7
    typedef logic [4:0]  imm_t;                 // Raw immediate field

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,                         // No operation
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SHL  = 4'h6,                         // Shift by low 4 bits of op2
        OP_SHR  = 4'h7,                         // Logical shift right
        OP_BRNZ = 4'hC                          // Branch if rs1 nonzero
    } opcode_t;

    // Instruction field positions
    localparam int OPC_HI       = 15;
    localparam int OPC_LO       = 12;
    localparam int IMM_FLAG_BIT = 11;           // Set when op2 is the immediate
    localparam int RD_HI        = 10;
    localparam int RD_LO        = 8;
    localparam int RS1_HI       = 7;
    localparam int RS1_LO       = 5;
    localparam int RS2_HI       = 4;
    localparam int RS2_LO       = 2;
    localparam int IMM_HI       = 4;            // Overlaps rs2
    localparam int IMM_LO       = 0;

    // ALU opcodes are the only ones that write rd
    function automatic logic writes_rd(opcode_t op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
    endfunction

endpackage

//--- core_pkg.sv
package core_pkg;

    // First fetch address after reset
    localparam isa_pkg::addr_t RESET_PC = 16'h0000;

    // Byte step per instruction, also the branch offset scale
    localparam isa_pkg::addr_t PC_STEP = 16'd4;

    // All-zero word decodes as NOP, used for bubbles
    localparam isa_pkg::word_t NOP_WORD = 16'h0000;

    // Shift amount taken from low bits of op2
    localparam int SHAMT_BITS = 4;

    // Instruction memory handshake states
    typedef enum logic [1:0] {
        F_IDLE,                                 // No request, ack seen low
        F_REQ,                                  // req high, waiting for ack
        F_WAIT_ACK_LOW                          // req dropped, waiting for ack low
    } fetch_state_t;

endpackage

//--- reg_file.sv
module reg_file
    import isa_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t rs1_idx,                   // Read port 1 index
    input  reg_idx_t rs2_idx,                   // Read port 2 index
    input  logic     wb_valid,                  // Write enable from writeback
    input  reg_idx_t wb_rd,                     // Write index
    input  word_t    wb_data,                   // Write value
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [0:7];                          // Eight general registers

    // Power-up contents come from the data file
    initial begin
        $readmemh("reg_file.hex", regs);
    end

    always_ff @(posedge clk) begin
        if (wb_valid) begin
            regs[wb_rd] <= wb_data;             // Single write port
        end
    end

    // Same-cycle write shows up on the read ports
    assign rs1_data = (wb_valid && (wb_rd == rs1_idx)) ? wb_data : regs[rs1_idx];
    assign rs2_data = (wb_valid && (wb_rd == rs2_idx)) ? wb_data : regs[rs2_idx];

endmodule

//--- fetch_unit.sv
module fetch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  imem_ack,                     // Memory handshake ack
    input  word_t imem_data,                    // Valid while ack high
    input  logic  stall,                        // Decode holds the buffer
    input  logic  is_branch_taken,              // Redirect from execute
    input  addr_t redirect_pc,
    output logic  imem_req,
    output addr_t imem_addr,                    // Held while req high
    output logic  instr_valid,                  // Buffer full
    output word_t instr,
    output addr_t instr_pc
);

    fetch_state_t state;
    addr_t        pc;                           // Next address to request
    logic         discard;                      // In-flight word is stale
    logic         buf_free;                     // Buffer empty or emptying
    logic         start_req;
    logic         capture;                      // Load buffer this cycle

    assign buf_free  = !instr_valid || !stall || is_branch_taken;
    assign start_req = (state != F_REQ) && !imem_ack && buf_free;
    // A redirect in the ack cycle drops the word as well
    assign capture   = (state == F_REQ) && imem_ack && !discard && !is_branch_taken;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= F_IDLE;
            imem_req  <= 1'b0;
            imem_addr <= RESET_PC;
            pc        <= RESET_PC;
            discard   <= 1'b0;
        end else begin
            case (state)
                F_REQ: begin
                    if (imem_ack) begin
                        imem_req <= 1'b0;       // Step 3, data taken
                        discard  <= 1'b0;
                        state    <= F_WAIT_ACK_LOW;
                    end else if (is_branch_taken) begin
                        discard  <= 1'b1;       // Finish handshake, drop word
                    end
                end
                default: begin
                    if (start_req) begin
                        imem_req  <= 1'b1;
                        imem_addr <= is_branch_taken ? redirect_pc : pc;
                        state     <= F_REQ;
                    end else if (!imem_ack) begin
                        state     <= F_IDLE;    // Ack low, buffer still busy
                    end
                end
            endcase
            if (is_branch_taken) begin
                pc <= redirect_pc;
            end else if (capture) begin
                pc <= pc + PC_STEP;             // Sequential fetch
            end
        end
    end

    // Buffer occupancy, flush wins over load
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_valid <= 1'b0;
        end else if (is_branch_taken) begin
            instr_valid <= 1'b0;
        end else if (capture) begin
            instr_valid <= 1'b1;
        end else if (!stall) begin
            instr_valid <= 1'b0;                // Taken by decode
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            instr    <= imem_data;
            instr_pc <= imem_addr;
        end
    end

endmodule

//--- decode_unit.sv
module decode_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,               // Fetch buffer full
    input  word_t    instr,
    input  addr_t    instr_pc,
    input  logic     is_branch_taken,           // Flush request
    input  word_t    rs1_data,                  // From register file
    input  word_t    rs2_data,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    output logic     stall,                     // Hold fetch buffer
    output logic     id_valid,
    output opcode_t  opcode,
    output logic     imm_flag,
    output imm_t     imm,
    output reg_idx_t rd,
    output word_t    op1,
    output word_t    op2,
    output word_t    branch_target,             // Scaled offset, added in execute
    output addr_t    id_pc
);

    opcode_t in_opcode;                         // Opcode of buffered word
    logic    in_imm_flag;
    logic    hazard_rs1;
    logic    hazard_rs2;
    logic    take;                              // Buffer word enters decode
    word_t   dec_word;                          // Word or bubble being decoded
    opcode_t dec_opcode;
    logic    dec_imm_flag;
    imm_t    dec_imm;
    word_t   branch_off;

    // Register reads use the raw buffer fields
    assign in_opcode   = opcode_t'(instr[OPC_HI:OPC_LO]);
    assign in_imm_flag = instr[IMM_FLAG_BIT];
    assign rs1_idx     = instr[RS1_HI:RS1_LO];
    assign rs2_idx     = instr[RS2_HI:RS2_LO];

    // RAW check against the output stage only
    assign hazard_rs1 = (writes_rd(in_opcode) || (in_opcode == OP_BRNZ)) && (rs1_idx == rd);
    assign hazard_rs2 = writes_rd(in_opcode) && !in_imm_flag && (rs2_idx == rd);
    // Older results are covered by the register file bypass
    assign stall      = instr_valid && id_valid && writes_rd(opcode)
                        && (hazard_rs1 || hazard_rs2);

    assign take = instr_valid && !stall && !is_branch_taken;

    // Flush over stall over empty buffer
    always_comb begin
        if (is_branch_taken) begin
            dec_word = NOP_WORD;                // Kill wrong-path word
        end else if (stall) begin
            dec_word = NOP_WORD;                // Bubble until writeback
        end else if (instr_valid) begin
            dec_word = instr;
        end else begin
            dec_word = NOP_WORD;
        end
    end

    assign dec_opcode   = opcode_t'(dec_word[OPC_HI:OPC_LO]);
    assign dec_imm_flag = dec_word[IMM_FLAG_BIT];
    assign dec_imm      = dec_word[IMM_HI:IMM_LO];
    // Sign extend, then scale to bytes
    assign branch_off   = {{11{dec_imm[4]}}, dec_imm} * PC_STEP;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
            opcode   <= OP_NOP;
            imm_flag <= 1'b0;
            rd       <= '0;
        end else begin
            id_valid <= take;
            opcode   <= dec_opcode;
            imm_flag <= dec_imm_flag;
            rd       <= dec_word[RD_HI:RD_LO];
        end
    end

    always_ff @(posedge clk) begin
        imm           <= dec_imm;
        op1           <= rs1_data;
        op2           <= dec_imm_flag ? {11'b0, dec_imm} : rs2_data;    // Zero-extended imm
        branch_target <= (dec_opcode == OP_BRNZ) ? branch_off : '0;
        id_pc         <= instr_pc;
    end

endmodule

//--- execute_unit.sv
module execute_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     id_valid,                  // Decode output holds an instruction
    input  opcode_t  opcode,
    input  reg_idx_t rd,
    input  word_t    op1,                       // rs1 value
    input  word_t    op2,                       // rs2 value or immediate
    input  word_t    branch_target,             // Byte offset from decode
    input  addr_t    id_pc,
    output logic     is_branch_taken,           // One cycle per taken branch
    output addr_t    redirect_pc,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    word_t                 alu_result;
    logic                  do_write;            // Writing opcode in this slot
    logic [SHAMT_BITS-1:0] shamt;

    assign shamt = op2[SHAMT_BITS-1:0];

    always_comb begin
        case (opcode)
            OP_ADD: begin
                alu_result = op1 + op2;
            end
            OP_SUB: begin
                alu_result = op1 - op2;
            end
            OP_AND: begin
                alu_result = op1 & op2;
            end
            OP_OR: begin
                alu_result = op1 | op2;
            end
            OP_XOR: begin
                alu_result = op1 ^ op2;
            end
            OP_SHL: begin
                alu_result = op1 << shamt;
            end
            OP_SHR: begin
                alu_result = op1 >> shamt;      // Zero fill
            end
            default: begin
                alu_result = '0;                // NOP, branch, unused codes
            end
        endcase
    end

    assign do_write = id_valid && writes_rd(opcode);

    // Branch resolves while in decode output register
    assign is_branch_taken = id_valid && (opcode == OP_BRNZ) && (op1 != '0);
    assign redirect_pc     = id_pc + branch_target;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= do_write;
        end
    end

    // Result held until the next writing instruction
    always_ff @(posedge clk) begin
        if (do_write) begin
            wb_rd   <= rd;
            wb_data <= alu_result;
        end
    end

endmodule

//--- core_top.sv
module core_top
    import isa_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     imem_ack,
    input  word_t    imem_data,
    output logic     imem_req,
    output addr_t    imem_addr,
    output logic     wb_valid,                  // Also the register file write
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    // Fetch to decode
    logic     instr_valid;
    word_t    instr;
    addr_t    instr_pc;
    logic     stall;

    // Execute back to fetch and decode
    logic     is_branch_taken;
    addr_t    redirect_pc;

    // Register file read ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    // Decode to execute
    logic     id_valid;
    opcode_t  opcode;
    reg_idx_t rd;
    word_t    op1;
    word_t    op2;
    word_t    branch_target;
    addr_t    id_pc;

    fetch_unit fetch0 (
        .clk             (clk),
        .reset           (reset),
        .imem_ack        (imem_ack),
        .imem_data       (imem_data),
        .stall           (stall),
        .is_branch_taken (is_branch_taken),
        .redirect_pc     (redirect_pc),
        .imem_req        (imem_req),
        .imem_addr       (imem_addr),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .instr_pc        (instr_pc)
    );

    // imm and imm_flag are already folded into op2
    decode_unit decode0 (
        .clk             (clk),
        .reset           (reset),
        .instr_valid     (instr_valid),
        .instr           (instr),
        .instr_pc        (instr_pc),
        .is_branch_taken (is_branch_taken),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .stall           (stall),
        .id_valid        (id_valid),
        .opcode          (opcode),
        .imm_flag        (),
        .imm             (),
        .rd              (rd),
        .op1             (op1),
        .op2             (op2),
        .branch_target   (branch_target),
        .id_pc           (id_pc)
    );

    reg_file regs0 (
        .clk             (clk),
        .rs1_idx         (rs1_idx),
        .rs2_idx         (rs2_idx),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    execute_unit execute0 (
        .clk             (clk),
        .reset           (reset),
        .id_valid        (id_valid),
        .opcode          (opcode),
        .rd              (rd),
        .op1             (op1),
        .op2             (op2),
        .branch_target   (branch_target),
        .id_pc           (id_pc),
        .is_branch_taken (is_branch_taken),
        .redirect_pc     (redirect_pc),
        .wb_valid        (wb_valid),
        .wb_rd           (wb_rd),
        .wb_data         (wb_data)
    );

endmodule

//--- core_assert.sv
module core_assert
    import isa_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  imem_req,
    input logic  imem_ack,
    input addr_t imem_addr,
    input logic  is_branch_taken,
    input logic  wb_valid
);

    int fail_count = 0;                             // Failed assertions so far

    addr_held: assert property (@(posedge clk) disable iff (reset)
        imem_req && $past(imem_req) |-> $stable(imem_addr))
        else begin
            $error("imem_addr changed during a request");
            fail_count++;
        end

    // Four-phase rule, ack must be low before the next request
    req_after_ack_low: assert property (@(posedge clk) disable iff (reset)
        $rose(imem_req) |-> !$past(imem_ack))
        else begin
            $error("imem_req rose while imem_ack was high");
            fail_count++;
        end

    branch_single: assert property (@(posedge clk) disable iff (reset)
        is_branch_taken |=> !is_branch_taken)       // Bubble follows the branch
        else begin
            $error("is_branch_taken held for more than one cycle");
            fail_count++;
        end

    wb_idle_in_reset: assert property (@(posedge clk) reset |-> !wb_valid)
        else begin
            $error("wb_valid high during reset");
            fail_count++;
        end

endmodule

bind core_top core_assert assert0 (
    .clk             (clk),
    .reset           (reset),
    .imem_req        (imem_req),
    .imem_ack        (imem_ack),
    .imem_addr       (imem_addr),
    .is_branch_taken (is_branch_taken),
    .wb_valid        (wb_valid)
);

//--- core_tb.sv
module core_tb
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int          PROG_LEN       = 16;
    localparam int          N_EXP          = 9;
    localparam int          TIMEOUT_CYCLES = 30 * N_EXP + 50;
    localparam int          QUIET_CYCLES   = 40;    // Silence after the last row
    localparam int          MAX_ACK_DELAY  = 3;
    localparam int unsigned SEED           = 32'h15bd;

    // Expected writebacks in program order
    localparam int    EXP_RD   [N_EXP] = '{1, 3, 2, 2, 6, 4, 7, 5, 6};
    localparam word_t EXP_DATA [N_EXP] = '{
        16'h0003,                                   // add  r1 = 1 + 2
        16'h0000,                                   // sub  r3 = 3 - 3
        16'h0012,                                   // or   r2 = 02 | 10
        16'h000D,                                   // xori r2 = 12 ^ 1F
        16'h000D,                                   // and  r6 = FF & 0D
        16'h0100,                                   // shli r4 = 10 << 4
        16'h1000,                                   // shr  r7 = 8000 >> 3
        16'h001F,                                   // subi r5 = 20 - 1
        16'h0020                                    // addi r6 = 1F + 1, branch target
    };

    logic     clk;
    logic     reset;
    logic     imem_ack;
    word_t    imem_data;
    logic     imem_req;
    addr_t    imem_addr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    word_t    prog [PROG_LEN];                      // Instruction memory contents
    int       errors;
    int       rows_seen;
    logic     collecting;                           // Watchdog armed

    core_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .imem_ack  (imem_ack),
        .imem_data (imem_data),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    function automatic word_t encode_reg(opcode_t op, int rd, int rs1, int rs2);
        return {op, 1'b0, rd[2:0], rs1[2:0], rs2[2:0], 2'b00};
    endfunction

    function automatic word_t encode_imm(opcode_t op, int rd, int rs1, int imm);
        return {op, 1'b1, rd[2:0], rs1[2:0], imm[4:0]};
    endfunction

    // NOP past the end of the program
    function automatic word_t read_prog(addr_t addr);
        int idx;
        idx = int'(addr / PC_STEP);
        if (idx < PROG_LEN) begin
            return prog[idx];
        end else begin
            return NOP_WORD;
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Four-phase memory with random ack latency, zero delay acks in the req cycle
    initial begin
        int unsigned delay;
        void'($urandom(SEED));
        imem_ack  = 1'b0;
        imem_data = NOP_WORD;
        forever begin
            @(posedge clk);
            #1;
            if (imem_req && !imem_ack) begin
                delay = $urandom_range(MAX_ACK_DELAY, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                imem_data = read_prog(imem_addr);
                imem_ack  = 1'b1;
                do begin
                    @(posedge clk);
                    #1;
                end while (imem_req);                   // Fetch drops req after capture
                imem_ack  = 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        wait (collecting);
        while (collecting && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (collecting) begin
            $display("Timeout after %0d cycles, %0d of %0d expected writebacks are missing",
                     cycles, N_EXP - rows_seen, N_EXP);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        errors     = 0;
        rows_seen  = 0;
        collecting = 1'b0;
        reset      = 1'b1;
        prog[0]  = encode_reg(OP_ADD, 1, 1, 2);
        prog[1]  = encode_reg(OP_SUB, 3, 1, 3);         // r1 from the word before
        prog[2]  = encode_reg(OP_OR, 2, 2, 4);
        prog[3]  = encode_imm(OP_XOR, 2, 2, 31);
        prog[4]  = encode_reg(OP_AND, 6, 6, 2);         // Hazard on rs2
        prog[5]  = encode_imm(OP_SHL, 4, 4, 4);
        prog[6]  = encode_reg(OP_SHR, 7, 7, 1);
        prog[7]  = encode_imm(OP_BRNZ, 0, 3, 3);        // r3 zero, falls through
        prog[8]  = NOP_WORD;
        prog[9]  = encode_reg(opcode_t'(4'h9), 5, 1, 1);
        prog[10] = encode_imm(OP_SUB, 5, 5, 1);
        prog[11] = encode_imm(OP_BRNZ, 0, 5, 3);        // Taken, lands on word 14
        prog[12] = encode_reg(OP_ADD, 1, 1, 1);         // Skipped
        prog[13] = encode_imm(OP_OR, 2, 0, 5);          // Skipped
        prog[14] = encode_imm(OP_ADD, 6, 5, 1);
        prog[15] = encode_imm(OP_BRNZ, 0, 6, 0);        // Spins on itself
        repeat (3) @(posedge clk);
        #1;
        reset      = 1'b0;
        collecting = 1'b1;

        do @(negedge clk); while (!imem_req);
        assert (imem_addr == RESET_PC) else begin
            errors++;
            $display("** Error at %0t: first fetch from %h, expected %h",
                     $time, imem_addr, RESET_PC);
        end

        for (int i = 0; i < N_EXP; i++) begin
            do @(negedge clk); while (!wb_valid);      // One pulse per row
            assert (int'(wb_rd) == EXP_RD[i] && wb_data == EXP_DATA[i]) else begin
                errors++;
                $display("** Error at %0t: writeback %0d is r%0d = %h, expected r%0d = %h",
                         $time, i, wb_rd, wb_data, EXP_RD[i], EXP_DATA[i]);
            end
            rows_seen++;
        end
        collecting = 1'b0;

        // Spin loop and skipped words stay silent
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!wb_valid) else begin
                errors++;
                $display("** Error at %0t: unexpected writeback r%0d = %h",
                         $time, wb_rd, wb_data);
            end
        end

        errors += dut0.assert0.fail_count;              // Bound handshake and pipeline rules
        $display("Run finished with %0d errors over %0d writebacks", errors, rows_seen);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- reg_file.hex
// r0 to r7, one 16-bit hex word per line
0000
0001
0002
0003
0010
0020
00FF
8000

//--- files.f
isa_pkg.sv
core_pkg.sv
reg_file.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
core_top.sv
core_assert.sv
core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= All checks passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
